// File: rtl/requant_defs.svh
//######################################################################
// Build-time sizes of the requantizer. REQ_BITS_OUT must be below
// REQ_BITS_IN and REQ_WIN_LEN must be a power of two
//######################################################################
`ifndef REQUANT_DEFS_SVH
`define REQUANT_DEFS_SVH

// Number of parallel channels
`define REQ_CH_NUM 2

// Sample widths before and after requantization
`define REQ_BITS_IN 16
`define REQ_BITS_OUT 12

// Valid results per statistics window
`define REQ_WIN_LEN 16

`endif

// File: rtl/requant_types_pkg.sv
//######################################################################
// Sample, error and statistics word types, sized from the defs header
//######################################################################
`include "requant_defs.svh"

package requant_types_pkg;

    // Derived widths
    localparam int DROP_W = `REQ_BITS_IN - `REQ_BITS_OUT;
    localparam int ERR_W  = DROP_W + 1;
    localparam int SUM_W  = ERR_W + $clog2(`REQ_WIN_LEN);

    typedef logic signed [`REQ_BITS_IN-1:0] sample_in_t;
    typedef logic signed [`REQ_BITS_OUT-1:0] sample_out_t;

    // Input minus rescaled output
    typedef logic signed [ERR_W-1:0] round_err_t;

    // Window statistics
    typedef logic signed [SUM_W-1:0] err_sum_t;
    typedef logic [ERR_W-1:0] err_mag_t;

endpackage

// File: rtl/round_ctrl_pkg.sv
//######################################################################
// Rounding mode codes. Code 3 is illegal and is never latched
//######################################################################
package round_ctrl_pkg;

    typedef enum logic [1:0] {
        RND_TRUNC   = 2'd0,  // toward negative infinity
        RND_ZERO    = 2'd1,
        RND_NEAREST = 2'd2
    } round_mode_t;

    // Unused encoding, rejected on load
    localparam logic [1:0] RND_CODE_ILLEGAL = 2'd3;

endpackage

// File: rtl/round_result_if.sv
//######################################################################
// Rounded sample set with errors and mode tag. Strobe only, no ready
//######################################################################
`timescale 1ns/1ps
`include "requant_defs.svh"

interface round_result_if;

    logic                                                  valid;
    requant_types_pkg::sample_out_t [`REQ_CH_NUM-1:0]      data;
    requant_types_pkg::round_err_t  [`REQ_CH_NUM-1:0]      err;
    round_ctrl_pkg::round_mode_t                           mode;

    // Rounding stage side
    modport src (
        output valid, data, err, mode
    );

    // Statistics side
    modport mon (
        input valid, data, err, mode
    );

endinterface

// File: rtl/round_mode_ctrl.sv
//######################################################################
// Mode register with one-hot enables. A load takes effect for samples
// entering on the next cycle; loads of the illegal code are dropped
//######################################################################
`timescale 1ns/1ps

module round_mode_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  round_ctrl_pkg::round_mode_t mode_i,
    input  logic                        mode_load_i,
    output round_ctrl_pkg::round_mode_t mode_o,
    output logic                        round_to_zero_o,
    output logic                        round_to_nearest_o,
    output logic                        trunc_o
);

    round_ctrl_pkg::round_mode_t mode_d;

    // Enables decode from the next mode so they line up with mode_o
    assign mode_d = (mode_load_i && mode_i != round_ctrl_pkg::RND_CODE_ILLEGAL) ?
                    mode_i : mode_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mode_o             <= round_ctrl_pkg::RND_TRUNC;
            round_to_zero_o    <= 1'b0;
            round_to_nearest_o <= 1'b0;
            trunc_o            <= 1'b1;
        end else begin
            mode_o             <= mode_d;
            round_to_zero_o    <= (mode_d == round_ctrl_pkg::RND_ZERO);
            round_to_nearest_o <= (mode_d == round_ctrl_pkg::RND_NEAREST);
            trunc_o            <= (mode_d == round_ctrl_pkg::RND_TRUNC);
        end
    end

    // An illegal code in the register would leave every enable low
    a_enables_onehot : assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot({round_to_zero_o, round_to_nearest_o, trunc_o}));

endmodule

// File: rtl/round.sv
//######################################################################
// One-stage requantizer. No saturation: only round to nearest guards
// against wrapping at the positive maximum. Enables must be one-hot
//######################################################################
`timescale 1ns/1ps
`include "requant_defs.svh"

module round (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic                                         round_to_zero_i,
    input  logic                                         round_to_nearest_i,
    input  logic                                         trunc_i,
    input  round_ctrl_pkg::round_mode_t                  mode_i,
    input  requant_types_pkg::sample_in_t [`REQ_CH_NUM-1:0] tdata_i,
    input  logic                                         tvalid_i,
    round_result_if.src                                  res
);

    localparam int CH       = `REQ_CH_NUM;
    localparam int BITS_IN  = `REQ_BITS_IN;
    localparam int BITS_OUT = `REQ_BITS_OUT;
    localparam int K        = BITS_IN - BITS_OUT;
    localparam int HALF     = 1 << (K - 1);
    localparam logic [BITS_OUT-1:0] MAX_POS = {1'b0, {(BITS_OUT - 1) {1'b1}}};

    requant_types_pkg::sample_out_t [CH-1:0] out;
    requant_types_pkg::round_err_t  [CH-1:0] err;

    always_comb begin
        logic [BITS_OUT-1:0] kept;
        logic [BITS_IN-1:0]  diff;
        logic                corr_rtz;
        logic                corr_near;
        logic                corr;
        for (int i = 0; i < CH; i++) begin
            kept      = tdata_i[i][BITS_IN-1:K];
            corr_rtz  = tdata_i[i][BITS_IN-1] & (|tdata_i[i][K-1:0]);
            // Half-step bit, suppressed where the kept word would wrap
            corr_near = tdata_i[i][K-1] & (kept != MAX_POS);
            if (trunc_i) begin
                corr = 1'b0;
            end else if (round_to_nearest_i) begin
                corr = corr_near;
            end else if (round_to_zero_i) begin
                corr = corr_rtz;
            end else begin
                corr = 1'b0;
            end
            out[i] = kept + {{(BITS_OUT - 1) {1'b0}}, corr};
            diff   = tdata_i[i] - {out[i], {K{1'b0}}};
            err[i] = diff[K:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= tvalid_i;
        end
        res.data <= out;
        res.err  <= err;
        res.mode <= mode_i;
    end

    a_enables_onehot0 : assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({round_to_zero_i, round_to_nearest_i, trunc_i}));

    // Nearest mode error stays within half a step unless the output pinned at max
    for (genvar i = 0; i < CH; i++) begin : g_chk
        a_nearest_err : assert property (@(posedge clk_i) disable iff (rst_i)
            (res.valid && res.mode == round_ctrl_pkg::RND_NEAREST) |->
            ((res.err[i] >= -HALF && res.err[i] < HALF) || res.data[i] == MAX_POS));
    end

endmodule

// File: rtl/error_monitor.sv
//######################################################################
// Per-channel rounding noise over fixed windows of valid results.
// A mode change drops the partial window; outputs hold between pulses
//######################################################################
`timescale 1ns/1ps
`include "requant_defs.svh"

module error_monitor (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    round_result_if.mon                                   res,
    output requant_types_pkg::err_sum_t [`REQ_CH_NUM-1:0] err_sum_o,
    output requant_types_pkg::err_mag_t [`REQ_CH_NUM-1:0] err_peak_o,
    output logic                                          stats_valid_o
);

    localparam int CH    = `REQ_CH_NUM;
    localparam int WIN   = `REQ_WIN_LEN;
    localparam int CNT_W = (WIN > 1) ? $clog2(WIN) : 1;

    logic [CNT_W-1:0]            cnt;
    logic [CNT_W-1:0]            base_cnt;
    round_ctrl_pkg::round_mode_t last_mode;
    logic                        restart;
    logic                        full;

    requant_types_pkg::err_sum_t [CH-1:0] acc_sum;
    requant_types_pkg::err_sum_t [CH-1:0] sum_nxt;
    requant_types_pkg::err_mag_t [CH-1:0] acc_peak;
    requant_types_pkg::err_mag_t [CH-1:0] peak_nxt;

    // Empty count means the accumulators hold nothing of this window
    assign restart  = (res.mode != last_mode) || (cnt == '0);
    assign base_cnt = restart ? '0 : cnt;
    assign full     = (base_cnt == CNT_W'(WIN - 1));

    always_comb begin
        requant_types_pkg::err_mag_t mag;
        requant_types_pkg::err_mag_t base_peak;
        for (int i = 0; i < CH; i++) begin
            // Most negative error maps to 2^k, still fits unsigned
            mag        = (res.err[i] < 0) ? requant_types_pkg::err_mag_t'(-res.err[i]) :
                                            requant_types_pkg::err_mag_t'(res.err[i]);
            base_peak  = restart ? '0 : acc_peak[i];
            sum_nxt[i] = (restart ? '0 : acc_sum[i]) +
                         requant_types_pkg::err_sum_t'(res.err[i]);
            peak_nxt[i] = (mag > base_peak) ? mag : base_peak;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt           <= '0;
            last_mode     <= round_ctrl_pkg::RND_TRUNC;
            stats_valid_o <= 1'b0;
        end else begin
            stats_valid_o <= res.valid && full;
            if (res.valid) begin
                last_mode <= res.mode;
                cnt       <= full ? '0 : base_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (res.valid) begin
            acc_sum  <= sum_nxt;
            acc_peak <= peak_nxt;
            if (full) begin
                err_sum_o  <= sum_nxt;
                err_peak_o <= peak_nxt;
            end
        end
    end

    if (WIN > 1) begin : g_win_chk
        // A window takes at least WIN results, so pulses are never adjacent
        a_stats_spacing : assert property (@(posedge clk_i) disable iff (rst_i)
            stats_valid_o |=> !stats_valid_o);
    end

endmodule

// File: rtl/requant_top.sv
//######################################################################
// Requantizer top. One cycle from tvalid_i to tvalid_o, two to the
// statistics pulse. No back-pressure; results must be taken as issued
//######################################################################
`timescale 1ns/1ps
`include "requant_defs.svh"

module requant_top (
    input  logic                                           clk_i,
    input  logic                                           rst_i,
    input  round_ctrl_pkg::round_mode_t                    mode_i,
    input  logic                                           mode_load_i,
    input  requant_types_pkg::sample_in_t  [`REQ_CH_NUM-1:0] tdata_i,
    input  logic                                           tvalid_i,
    output requant_types_pkg::sample_out_t [`REQ_CH_NUM-1:0] tdata_o,
    output requant_types_pkg::round_err_t  [`REQ_CH_NUM-1:0] err_o,
    output logic                                           tvalid_o,
    output requant_types_pkg::err_sum_t    [`REQ_CH_NUM-1:0] err_sum_o,
    output requant_types_pkg::err_mag_t    [`REQ_CH_NUM-1:0] err_peak_o,
    output logic                                           stats_valid_o
);

    round_ctrl_pkg::round_mode_t mode;
    logic                        round_to_zero;
    logic                        round_to_nearest;
    logic                        trunc;

    round_result_if res ();

    round_mode_ctrl u_mode_ctrl (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .mode_i             (mode_i),
        .mode_load_i        (mode_load_i),
        .mode_o             (mode),
        .round_to_zero_o    (round_to_zero),
        .round_to_nearest_o (round_to_nearest),
        .trunc_o            (trunc)
    );

    round u_round (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .round_to_zero_i    (round_to_zero),
        .round_to_nearest_i (round_to_nearest),
        .trunc_i            (trunc),
        .mode_i             (mode),
        .tdata_i            (tdata_i),
        .tvalid_i           (tvalid_i),
        .res                (res.src)
    );

    error_monitor u_err_mon (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .res           (res.mon),
        .err_sum_o     (err_sum_o),
        .err_peak_o    (err_peak_o),
        .stats_valid_o (stats_valid_o)
    );

    // Rounded stream also leaves the design directly
    assign tdata_o  = res.data;
    assign err_o    = res.err;
    assign tvalid_o = res.valid;

endmodule

// File: tests/requant_tb.sv
//######################################################################
// Testbench for requant_top. Must run from the project root so that
// tests/requant_stim.txt is found. Vector file assumes two channels
//######################################################################
`timescale 1ns/1ps
`include "requant_defs.svh"

module requant_tb;

    localparam int CH        = `REQ_CH_NUM;
    localparam int BITS_IN   = `REQ_BITS_IN;
    localparam int BITS_OUT  = `REQ_BITS_OUT;
    localparam int WIN       = `REQ_WIN_LEN;
    localparam int K         = BITS_IN - BITS_OUT;
    localparam int ERR_W     = K + 1;
    localparam int STEP      = 1 << K;
    localparam int OUT_MAX   = (1 << (BITS_OUT - 1)) - 1;
    localparam int VEC_W     = 1 + 3 * CH;
    localparam int MAX_VEC   = 64;
    localparam int TIMEOUT   = 50;
    localparam int DRIVE_DLY = 2;
    localparam int RAND_LEN  = 40;
    localparam logic [BITS_IN-1:0] END_MARK = '1;

    typedef struct packed {
        logic [31:0]                             stamp;
        requant_types_pkg::sample_out_t [CH-1:0] data;
        requant_types_pkg::round_err_t  [CH-1:0] err;
    } res_exp_t;

    typedef struct packed {
        logic [31:0]                          stamp;
        requant_types_pkg::err_sum_t [CH-1:0] sum;
        requant_types_pkg::err_mag_t [CH-1:0] peak;
    } stats_exp_t;

    logic                                    clk_i;
    logic                                    rst_i;
    round_ctrl_pkg::round_mode_t             mode_i;
    logic                                    mode_load_i;
    requant_types_pkg::sample_in_t  [CH-1:0] tdata_i;
    logic                                    tvalid_i;
    requant_types_pkg::sample_out_t [CH-1:0] tdata_o;
    requant_types_pkg::round_err_t  [CH-1:0] err_o;
    logic                                    tvalid_o;
    requant_types_pkg::err_sum_t    [CH-1:0] err_sum_o;
    requant_types_pkg::err_mag_t    [CH-1:0] err_peak_o;
    logic                                    stats_valid_o;

    res_exp_t                    res_q [$];
    stats_exp_t                  stats_q [$];
    round_ctrl_pkg::round_mode_t cur_mode;
    round_ctrl_pkg::round_mode_t win_mode;
    int                          win_cnt;
    int                          win_sum [CH];
    int                          win_peak [CH];
    logic [31:0]                 cyc;
    logic [31:0]                 lcg_state;
    int                          err_cnt;
    int                          stats_seen;
    int                          n_tests;
    int                          n_failed;
    logic [BITS_IN-1:0]          stim [MAX_VEC * VEC_W];

    requant_top dut_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mode_i        (mode_i),
        .mode_load_i   (mode_load_i),
        .tdata_i       (tdata_i),
        .tvalid_i      (tvalid_i),
        .tdata_o       (tdata_o),
        .err_o         (err_o),
        .tvalid_o      (tvalid_o),
        .err_sum_o     (err_sum_o),
        .err_peak_o    (err_peak_o),
        .stats_valid_o (stats_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 32'd1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Floor, truncating division, or half-up with a clamp at the positive maximum
    function automatic int model_out(input int x, input round_ctrl_pkg::round_mode_t m);
        int y;
        if (m == round_ctrl_pkg::RND_ZERO) begin
            y = x / STEP;
        end else if (m == round_ctrl_pkg::RND_NEAREST) begin
            y = (x + STEP / 2) >>> K;
            if (y > OUT_MAX) begin
                y = OUT_MAX;
            end
        end else begin
            y = x >>> K;
        end
        return y;
    endfunction

    task automatic window_update(input requant_types_pkg::round_err_t [CH-1:0] e);
        stats_exp_t s;
        int         ei;
        if (cur_mode != win_mode || win_cnt == 0) begin
            win_cnt = 0;
            for (int c = 0; c < CH; c++) begin
                win_sum[c]  = 0;
                win_peak[c] = 0;
            end
        end
        win_mode = cur_mode;
        for (int c = 0; c < CH; c++) begin
            ei          = $signed(e[c]);
            win_sum[c] += ei;
            if (ei < 0) begin
                ei = -ei;
            end
            if (ei > win_peak[c]) begin
                win_peak[c] = ei;
            end
        end
        win_cnt++;
        if (win_cnt == WIN) begin
            s.stamp = cyc;
            for (int c = 0; c < CH; c++) begin
                s.sum[c]  = requant_types_pkg::err_sum_t'(win_sum[c]);
                s.peak[c] = requant_types_pkg::err_mag_t'(win_peak[c]);
            end
            stats_q.push_back(s);
            win_cnt = 0;
        end
    endtask

    task automatic drive_cycle(input logic valid,
                               input requant_types_pkg::sample_in_t  [CH-1:0] d,
                               input requant_types_pkg::sample_out_t [CH-1:0] exp_d,
                               input requant_types_pkg::round_err_t  [CH-1:0] exp_e);
        res_exp_t r;
        @(posedge clk_i);
        #DRIVE_DLY;
        mode_load_i = 1'b0;
        tvalid_i    = valid;
        tdata_i     = d;
        if (valid) begin
            r.stamp = cyc;
            r.data  = exp_d;
            r.err   = exp_e;
            res_q.push_back(r);
            window_update(exp_e);
        end
    endtask

    task automatic send_model(input requant_types_pkg::sample_in_t [CH-1:0] d);
        requant_types_pkg::sample_out_t [CH-1:0] od;
        requant_types_pkg::round_err_t  [CH-1:0] oe;
        int                                      xi;
        int                                      y;
        for (int c = 0; c < CH; c++) begin
            xi    = $signed(d[c]);
            y     = model_out(xi, cur_mode);
            od[c] = requant_types_pkg::sample_out_t'(y);
            oe[c] = requant_types_pkg::round_err_t'(xi - y * STEP);
        end
        drive_cycle(1'b1, d, od, oe);
    endtask

    task automatic random_set(output requant_types_pkg::sample_in_t [CH-1:0] d);
        for (int c = 0; c < CH; c++) begin
            lcg_state = lcg_next(lcg_state);
            d[c]      = lcg_state[31:32-BITS_IN];
        end
    endtask

    // Illegal codes are sent to the DUT but leave the model mode alone
    task automatic load_mode(input logic [1:0] code);
        @(posedge clk_i);
        #DRIVE_DLY;
        tvalid_i    = 1'b0;
        mode_i      = round_ctrl_pkg::round_mode_t'(code);
        mode_load_i = 1'b1;
        if (code != round_ctrl_pkg::RND_CODE_ILLEGAL) begin
            cur_mode = round_ctrl_pkg::round_mode_t'(code);
        end
    endtask

    task automatic drain(input string what);
        int n;
        drive_cycle(1'b0, '0, '0, '0);
        n = 0;
        while ((res_q.size() > 0 || stats_q.size() > 0) && n < TIMEOUT) begin
            @(posedge clk_i);
            n++;
        end
        if (res_q.size() > 0 || stats_q.size() > 0) begin
            $display("Timed out in %s waiting for tvalid_o or stats_valid_o", what);
            err_cnt++;
            res_q.delete();
            stats_q.delete();
        end
    endtask

    task automatic finish_test(input string name, input int start);
        n_tests++;
        if (err_cnt == start) begin
            $display("Test %s: ok", name);
        end else begin
            n_failed++;
            $display("Test %s: %0d errors", name, err_cnt - start);
        end
    endtask

    // Outputs are compared at the falling edge, away from the register updates
    always @(negedge clk_i) begin
        res_exp_t   r;
        stats_exp_t s;
        logic       res_due;
        logic       stats_due;
        if (rst_i === 1'b0) begin
            res_due = (res_q.size() > 0) && (res_q[0].stamp + 32'd1 == cyc);
            assert (tvalid_o == res_due) else begin
                $display("ERROR t=%0t: tvalid_o is %0b, expected %0b", $time, tvalid_o, res_due);
                err_cnt++;
            end
            // A missing strobe leaves the entry queued until the drain times out
            if (res_due && tvalid_o) begin
                r = res_q.pop_front();
                for (int c = 0; c < CH; c++) begin
                    assert (tdata_o[c] == r.data[c] && err_o[c] == r.err[c]) else begin
                        $display("ERROR t=%0t: ch%0d tdata_o=%h err_o=%h, expected %h %h",
                                 $time, c, tdata_o[c], err_o[c], r.data[c], r.err[c]);
                        err_cnt++;
                    end
                end
            end
            stats_due = (stats_q.size() > 0) && (stats_q[0].stamp + 32'd2 == cyc);
            assert (stats_valid_o == stats_due) else begin
                $display("ERROR t=%0t: stats_valid_o is %0b, expected %0b",
                         $time, stats_valid_o, stats_due);
                err_cnt++;
            end
            if (stats_valid_o) begin
                stats_seen++;
            end
            if (stats_due && stats_valid_o) begin
                s = stats_q.pop_front();
                for (int c = 0; c < CH; c++) begin
                    assert (err_sum_o[c] == s.sum[c] && err_peak_o[c] == s.peak[c]) else begin
                        $display("ERROR t=%0t: ch%0d err_sum_o=%h err_peak_o=%h, expected %h %h",
                                 $time, c, err_sum_o[c], err_peak_o[c], s.sum[c], s.peak[c]);
                        err_cnt++;
                    end
                end
            end
        end
    end

    initial begin
        requant_types_pkg::sample_in_t  [CH-1:0] d;
        requant_types_pkg::sample_out_t [CH-1:0] od;
        requant_types_pkg::round_err_t  [CH-1:0] oe;
        int                                      n_vec;
        int                                      base;
        int                                      start;
        int                                      seen0;
        int                                      xi;
        int                                      y;

        rst_i       = 1'b1;
        mode_i      = round_ctrl_pkg::RND_TRUNC;
        mode_load_i = 1'b0;
        tdata_i     = '0;
        tvalid_i    = 1'b0;
        cyc         = 32'd0;
        lcg_state   = 32'd64;
        err_cnt     = 0;
        stats_seen  = 0;
        n_tests     = 0;
        n_failed    = 0;
        cur_mode    = round_ctrl_pkg::RND_TRUNC;
        win_mode    = round_ctrl_pkg::RND_TRUNC;
        win_cnt     = 0;
        stim[0]     = END_MARK;
        $readmemh("tests/requant_stim.txt", stim);

        repeat (16) @(posedge clk_i);
        #DRIVE_DLY;
        rst_i = 1'b0;

        // Quiet after reset, then one half-step sample must come out truncated
        start = err_cnt;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk_i);
            assert (!tvalid_o && !stats_valid_o) else begin
                $display("ERROR t=%0t: output strobe high with no input", $time);
                err_cnt++;
            end
        end
        d    = '0;
        d[0] = requant_types_pkg::sample_in_t'(STEP + STEP / 2);
        d[CH-1] = requant_types_pkg::sample_in_t'(-(STEP + STEP / 2));
        send_model(d);
        drain("reset test");
        finish_test("reset and default mode", start);

        start = err_cnt;
        n_vec = 0;
        while (n_vec < MAX_VEC && stim[n_vec * VEC_W] != END_MARK) begin
            n_vec++;
        end
        assert (n_vec > 0) else begin
            $display("No directed vectors were read from the stimulus file");
            err_cnt++;
        end
        for (int v = 0; v < n_vec; v++) begin
            base = v * VEC_W;
            if (stim[base][1:0] != cur_mode) begin
                load_mode(stim[base][1:0]);
            end
            for (int c = 0; c < CH; c++) begin
                d[c]  = stim[base + 1 + c];
                od[c] = stim[base + 1 + CH + c][BITS_OUT-1:0];
                oe[c] = stim[base + 1 + 2 * CH + c][ERR_W-1:0];
                xi    = $signed(d[c]);
                y     = model_out(xi, cur_mode);
                assert (od[c] == requant_types_pkg::sample_out_t'(y) &&
                        oe[c] == requant_types_pkg::round_err_t'(xi - y * STEP)) else begin
                    $display("Stimulus file and model disagree on vector %0d channel %0d", v, c);
                    err_cnt++;
                end
            end
            drive_cycle(1'b1, d, od, oe);
        end
        drain("directed vectors");
        finish_test("directed edge vectors", start);

        start = err_cnt;
        for (int mi = 0; mi < 3; mi++) begin
            load_mode(mi[1:0]);
            for (int i = 0; i < RAND_LEN; i++) begin
                lcg_state = lcg_next(lcg_state);
                if (lcg_state[31:30] == 2'b00) begin
                    drive_cycle(1'b0, '0, '0, '0);
                end else begin
                    random_set(d);
                    send_model(d);
                end
            end
        end
        drain("random samples");
        finish_test("random samples in all modes", start);

        start = err_cnt;
        load_mode(round_ctrl_pkg::RND_ZERO);
        seen0 = stats_seen;
        for (int i = 0; i < WIN; i++) begin
            if (i % 5 == 4) begin
                drive_cycle(1'b0, '0, '0, '0);
            end
            random_set(d);
            send_model(d);
        end
        drain("statistics window");
        assert (stats_seen == seen0 + 1) else begin
            $display("ERROR t=%0t: %0d statistics pulses, expected 1", $time, stats_seen - seen0);
            err_cnt++;
        end
        finish_test("statistics window", start);

        // Half a window in truncation, then a full one in nearest
        start = err_cnt;
        seen0 = stats_seen;
        load_mode(round_ctrl_pkg::RND_TRUNC);
        for (int i = 0; i < WIN / 2; i++) begin
            random_set(d);
            send_model(d);
        end
        load_mode(round_ctrl_pkg::RND_NEAREST);
        for (int i = 0; i < WIN; i++) begin
            random_set(d);
            send_model(d);
        end
        drain("window restart");
        assert (stats_seen == seen0 + 1) else begin
            $display("ERROR t=%0t: %0d statistics pulses, expected 1", $time, stats_seen - seen0);
            err_cnt++;
        end
        finish_test("mode change restarts window", start);

        start = err_cnt;
        load_mode(round_ctrl_pkg::RND_CODE_ILLEGAL);
        d    = '0;
        d[0] = requant_types_pkg::sample_in_t'(STEP + STEP / 2);
        send_model(d);
        for (int i = 0; i < 8; i++) begin
            random_set(d);
            send_model(d);
        end
        drain("illegal mode load");
        finish_test("illegal mode load ignored", start);

        $display("Tests run: %0d, failed: %0d, check errors: %0d", n_tests, n_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: tests/requant_stim.txt
// Columns: mode, ch0 in, ch1 in, ch0 out, ch1 out, ch0 err, ch1 err (all hex)
// Mode 0 truncates, 1 rounds toward zero, 2 rounds to nearest. Errors are 5-bit
// Truncation
0 0018 ffe8 001 ffe 08 08
0 8000 7fff 800 7ff 00 0f
0 7ff8 0008 7ff 000 08 08
0 fff8 8001 fff 800 08 01
0 1234 ffff 123 fff 04 0f
0 0000 fff0 000 fff 00 00
0 0007 fff9 000 fff 07 09
// Round toward zero
1 0018 ffe8 001 fff 08 18
1 8000 7fff 800 7ff 00 0f
1 7ff8 0008 7ff 000 08 08
1 fff8 8001 000 801 18 11
1 1234 ffff 123 000 04 1f
1 0000 fff0 000 fff 00 00
1 0007 fff9 000 000 07 19
// Round to nearest
// Positive maximum stays at 7ff
2 0018 ffe8 002 fff 18 18
2 8000 7fff 800 7ff 00 0f
2 7ff8 0008 7ff 001 08 18
2 fff8 8001 000 800 18 01
2 1234 ffff 123 000 04 1f
2 0000 fff0 000 fff 00 00
2 0007 fff9 000 000 07 19
// End marker
ffff

// File: tb.f
+incdir+rtl
rtl/requant_types_pkg.sv
rtl/round_ctrl_pkg.sv
rtl/round_result_if.sv
rtl/round_mode_ctrl.sv
rtl/round.sv
rtl/error_monitor.sv
rtl/requant_top.sv
tests/requant_tb.sv

// File: Makefile
# Verilator simulation of the requantizer testbench
VERILATOR ?= verilator
TOP       ?= requant_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
